// ==== verification/bridge_vectors.txt ====
// columns: op address word0 word1 word2 word3 aligned_address
// op 0 is a read, op 1 is a write-back; line words are listed from word 0 upward
00000000 00000013 a0000000 a0000001 a0000002 a0000003 00000010
00000001 00000105 b1110000 b1110001 b1110002 b1110003 00000104
00000000 00000106 c2220010 c2220011 c2220012 c2220013 00000104
00000001 0000ff2b 13572468 24681357 35790246 46801357 0000ff28
00000000 1234567f 0f0f0f0f f0f0f0f0 00ff00ff ff00ff00 1234567c
00000000 00000001 00000000 ffffffff 00000000 ffffffff 00000000
00000001 fffffffe 11111111 22222222 33333333 44444444 fffffffc
00000001 80000009 deadbeef cafef00d 8badf00d feedface 80000008
00000000 0badc0d2 01234567 89abcdef fedcba98 76543210 0badc0d0
00000001 00c0ffee 5a5a5a5a a5a5a5a5 3c3c3c3c c3c3c3c3 00c0ffec
00000000 7fffffff 7ffffff0 7ffffff1 7ffffff2 7ffffff3 7ffffffc
00000001 00000003 00000001 00000002 00000004 00000008 00000000
00000000 deadbeef 10203040 50607080 90a0b0c0 d0e0f000 deadbeec
00000001 13579bdf 9e3779b9 7f4a7c15 c2b2ae35 27d4eb2f 13579bdc
00000000 2468ace1 aaaa0001 bbbb0002 cccc0003 dddd0004 2468ace0
00000001 0000000a 80000001 40000002 20000004 10000008 00000008
00000000 55555555 55550000 00005555 aaaa0000 0000aaaa 55555554
00000001 aaaaaaaa 6b8b4567 327b23c6 643c9869 66334873 aaaaaaa8
00000000 fedcba97 74b0dc51 19495cff 2ae8944a 625558ec fedcba94
00000001 01010102 0a0b0c0d 1a1b1c1d 2a2b2c2d 3a3b3c3d 01010100

// ==== src.f ====
source/bus_msg_pkg.sv
source/bus_geometry_pkg.sv
source/line_buffer.sv
source/bridge_control.sv
source/lx_bus_bridge.sv
verification/tb_lx_bus_bridge.sv

// ==== Bender.yml ====
package:
  name: lx_bus_bridge

sources:
  - files:
      - source/bus_msg_pkg.sv
      - source/bus_geometry_pkg.sv
      - source/line_buffer.sv
      - source/bridge_control.sv
      - source/lx_bus_bridge.sv
  - target: test
    files:
      - verification/tb_lx_bus_bridge.sv

// ==== verification/tb_lx_bus_bridge.sv ====
`timescale 1ns/1ps

module tb_lx_bus_bridge;

  localparam int num_vectors     = 20;
  localparam int record_words    = 7; // op, address, four line words, aligned address
  localparam int line_words      = 4;
  localparam int beat_words      = 2;
  localparam int watchdog_cycles = num_vectors * 40 + 100;

  logic                                     clock = 1'b0;
  logic                                     reset;
  logic                                     bus_req_valid;
  logic                                     bus_req_ready;
  bus_msg_pkg::bus_msg_t                    bus_req_msg;
  bus_geometry_pkg::address_t               bus_req_address;
  logic                                     bus_wdata_valid;
  logic                                     bus_wdata_ready;
  bus_geometry_pkg::word_t [beat_words-1:0] bus_wdata;
  logic                                     bus_resp_valid;
  logic                                     bus_resp_ready;
  bus_msg_pkg::bus_msg_t                    bus_resp_msg;
  bus_geometry_pkg::word_t [beat_words-1:0] bus_resp_data;
  logic                                     bus_resp_last;
  logic                                     cache_req_valid;
  logic                                     cache_req_ready;
  logic                                     cache_req_write;
  bus_geometry_pkg::address_t               cache_req_address;
  bus_geometry_pkg::word_t [line_words-1:0] cache_req_data;
  logic                                     cache_resp_valid;
  bus_geometry_pkg::word_t [line_words-1:0] cache_resp_data;

  logic [31:0]                              vector_mem [0:num_vectors*record_words-1];
  bus_geometry_pkg::word_t [line_words-1:0] cur_line;    // line of the vector in flight
  bus_geometry_pkg::address_t               cur_aligned;
  logic                                     cur_write;
  logic [31:0]                              rand_word;

  // values seen on the last edge for the stall checks
  logic                                     resp_stalled;
  logic                                     cache_stalled;
  bus_msg_pkg::bus_msg_t                    held_resp_msg;
  bus_geometry_pkg::word_t [beat_words-1:0] held_resp_data;
  logic                                     held_resp_last;
  logic                                     held_cache_write;
  bus_geometry_pkg::address_t               held_cache_address;
  bus_geometry_pkg::word_t [line_words-1:0] held_cache_data;

  always #50 clock = ~clock;

  lx_bus_bridge u_dut (
    .clock             (clock),
    .reset             (reset),
    .bus_req_valid     (bus_req_valid),
    .bus_req_ready     (bus_req_ready),
    .bus_req_msg       (bus_req_msg),
    .bus_req_address   (bus_req_address),
    .bus_wdata_valid   (bus_wdata_valid),
    .bus_wdata_ready   (bus_wdata_ready),
    .bus_wdata         (bus_wdata),
    .bus_resp_valid    (bus_resp_valid),
    .bus_resp_ready    (bus_resp_ready),
    .bus_resp_msg      (bus_resp_msg),
    .bus_resp_data     (bus_resp_data),
    .bus_resp_last     (bus_resp_last),
    .cache_req_valid   (cache_req_valid),
    .cache_req_ready   (cache_req_ready),
    .cache_req_write   (cache_req_write),
    .cache_req_address (cache_req_address),
    .cache_req_data    (cache_req_data),
    .cache_resp_valid  (cache_resp_valid),
    .cache_resp_data   (cache_resp_data)
  );

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // words of beat k with the lowest word first
  function automatic logic [beat_words*32-1:0] line_slice(
    input bus_geometry_pkg::word_t [line_words-1:0] line, input int k);
    logic [beat_words*32-1:0] slice;
    for (int b = 0; b < beat_words; b++) begin
      slice[b*32 +: 32] = line[k*beat_words + b];
    end
    return slice;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch at time %0t: %s expected %0h actual %0h",
                         $time, name, expected, actual));
    end
  endtask

  // one edge inside a transaction where no new request may be taken
  task automatic wait_busy_edge();
    @(posedge clock);
    check_value("bus_req_ready", 1'b0, bus_req_ready);
  endtask

  task automatic send_request(input bus_msg_pkg::bus_msg_t msg,
                              input bus_geometry_pkg::address_t address);
    @(negedge clock);
    bus_req_valid   = 1'b1;
    bus_req_msg     = msg;
    bus_req_address = address;
    do begin
      @(posedge clock);
    end while (!bus_req_ready);
    @(negedge clock);
    bus_req_valid   = 1'b0;
    bus_req_msg     = bus_msg_pkg::no_req;
    bus_req_address = '0;
  endtask

  task automatic take_response(input bus_msg_pkg::bus_msg_t msg,
                               input logic [beat_words*32-1:0] data, input logic last);
    do begin
      wait_busy_edge();
    end while (!(bus_resp_valid && bus_resp_ready));
    check_value("bus_resp_msg", msg, bus_resp_msg);
    check_value("bus_resp_data", data, bus_resp_data);
    check_value("bus_resp_last", last, bus_resp_last);
  endtask

  task automatic run_read(input bus_geometry_pkg::address_t address);
    send_request(bus_msg_pkg::read_req, address);
    for (int k = 0; k < line_words / beat_words; k++) begin
      take_response(bus_msg_pkg::read_data, line_slice(cur_line, k),
                    k == line_words / beat_words - 1);
    end
    @(posedge clock);
    check_value("bus_req_ready", 1'b1, bus_req_ready); // idle again after the last beat
    check_value("bus_resp_valid", 1'b0, bus_resp_valid);
  endtask

  task automatic run_write(input bus_geometry_pkg::address_t address);
    send_request(bus_msg_pkg::write_req, address);
    for (int k = 0; k < line_words / beat_words; k++) begin
      bus_wdata_valid = 1'b1;
      bus_wdata       = line_slice(cur_line, k);
      do begin
        wait_busy_edge();
      end while (!bus_wdata_ready);
      @(negedge clock);
    end
    bus_wdata_valid = 1'b0;
    take_response(bus_msg_pkg::write_ack, '0, 1'b1);
    @(posedge clock);
    check_value("bus_req_ready", 1'b1, bus_req_ready);
    check_value("bus_resp_valid", 1'b0, bus_resp_valid); // a single ack only
  endtask

  // bus response and cache ready lines high about three cycles in four
  initial begin : stall_source
    rand_word       = 32'h1275_10d5;
    bus_resp_ready  = 1'b0;
    cache_req_ready = 1'b0;
    forever begin
      @(negedge clock);
      rand_word       = next_random(rand_word);
      bus_resp_ready  = rand_word[17:16] != 2'b00;
      cache_req_ready = rand_word[21:20] != 2'b00;
    end
  end

  initial begin : cache_model
    int delay;
    cache_resp_valid = 1'b0;
    cache_resp_data  = '0;
    forever begin
      @(posedge clock);
      if (!reset && cache_req_valid && cache_req_ready) begin
        check_value("cache_req_write", cur_write, cache_req_write);
        check_value("cache_req_address", cur_aligned, cache_req_address);
        if (cur_write) begin
          check_value("cache_req_data", cur_line, cache_req_data);
        end
        delay = (rand_word >> 8) % 6; // 0 to 5 extra cycles
        @(negedge clock);
        repeat (delay) @(negedge clock);
        cache_resp_valid = 1'b1;
        cache_resp_data  = cur_line;
        @(negedge clock);
        cache_resp_valid = 1'b0;
      end
    end
  end

  // a stalled channel keeps valid and every field
  always @(posedge clock) begin
    if (reset) begin
      resp_stalled  = 1'b0;
      cache_stalled = 1'b0;
    end else begin
      if (resp_stalled) begin
        check_value("bus_resp_valid", 1'b1, bus_resp_valid);
        check_value("bus_resp_msg", held_resp_msg, bus_resp_msg);
        check_value("bus_resp_data", held_resp_data, bus_resp_data);
        check_value("bus_resp_last", held_resp_last, bus_resp_last);
      end
      if (cache_stalled) begin
        check_value("cache_req_valid", 1'b1, cache_req_valid);
        check_value("cache_req_write", held_cache_write, cache_req_write);
        check_value("cache_req_address", held_cache_address, cache_req_address);
        check_value("cache_req_data", held_cache_data, cache_req_data);
      end
      resp_stalled       = bus_resp_valid && !bus_resp_ready;
      cache_stalled      = cache_req_valid && !cache_req_ready;
      held_resp_msg      = bus_resp_msg;
      held_resp_data     = bus_resp_data;
      held_resp_last     = bus_resp_last;
      held_cache_write   = cache_req_write;
      held_cache_address = cache_req_address;
      held_cache_data    = cache_req_data;
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clock);
    fail_run("timeout: the bridge did not finish all vectors in time");
  end

  initial begin : main_sequence
    int base;
    reset           = 1'b1;
    bus_req_valid   = 1'b0;
    bus_req_msg     = bus_msg_pkg::no_req;
    bus_req_address = '0;
    bus_wdata_valid = 1'b0;
    bus_wdata       = '0;
    cur_line        = '0;
    cur_aligned     = '0;
    cur_write       = 1'b0;
    $readmemh("verification/bridge_vectors.txt", vector_mem);
    if ($isunknown(vector_mem[num_vectors*record_words-1])) begin
      fail_run("the vector file could not be read or is too short");
    end
    repeat (16) @(negedge clock);
    reset = 1'b0;

    @(posedge clock);
    check_value("bus_req_ready", 1'b1, bus_req_ready);
    check_value("bus_resp_valid", 1'b0, bus_resp_valid);
    check_value("cache_req_valid", 1'b0, cache_req_valid);
    check_value("bus_wdata_ready", 1'b0, bus_wdata_ready);
    check_value("bus_resp_msg", bus_msg_pkg::no_req, bus_resp_msg);

    for (int i = 0; i < num_vectors; i++) begin
      base        = i * record_words;
      cur_write   = vector_mem[base][0]; // 1 is a write-back
      cur_aligned = vector_mem[base+6];
      for (int j = 0; j < line_words; j++) begin
        cur_line[j] = vector_mem[base+2+j];
      end
      if (cur_write) begin
        run_write(vector_mem[base+1]);
      end else begin
        run_read(vector_mem[base+1]);
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== source/lx_bus_bridge.sv ====
`timescale 1ns/1ps

module lx_bus_bridge #(
  parameter int CACHE_WORDS_LOG2 = 2, // words per cache line, log2
  parameter int BUS_WORDS_LOG2   = 1  // words per bus beat, log2
) (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic                                                  bus_req_valid,
  output logic                                                  bus_req_ready,
  input  bus_msg_pkg::bus_msg_t                                 bus_req_msg,
  input  bus_geometry_pkg::address_t                            bus_req_address,
  input  logic                                                  bus_wdata_valid,
  output logic                                                  bus_wdata_ready,
  input  bus_geometry_pkg::word_t [(1 << BUS_WORDS_LOG2)-1:0]   bus_wdata,
  output logic                                                  bus_resp_valid,
  input  logic                                                  bus_resp_ready,
  output bus_msg_pkg::bus_msg_t                                 bus_resp_msg,
  output bus_geometry_pkg::word_t [(1 << BUS_WORDS_LOG2)-1:0]   bus_resp_data,
  output logic                                                  bus_resp_last,
  output logic                                                  cache_req_valid,
  input  logic                                                  cache_req_ready,
  output logic                                                  cache_req_write,
  output bus_geometry_pkg::address_t                            cache_req_address,
  output bus_geometry_pkg::word_t [(1 << CACHE_WORDS_LOG2)-1:0] cache_req_data,
  input  logic                                                  cache_resp_valid,
  input  bus_geometry_pkg::word_t [(1 << CACHE_WORDS_LOG2)-1:0] cache_resp_data
);

  // controller to line buffer
  logic beat_clear;
  logic beat_write;
  logic beat_advance;
  logic line_load;
  logic beat_last; // buffer index sits on the final slice

  bridge_control #(
    .CACHE_WORDS_LOG2 (CACHE_WORDS_LOG2),
    .BUS_WORDS_LOG2   (BUS_WORDS_LOG2)
  ) u_control (
    .clock             (clock),
    .reset             (reset),
    .bus_req_valid     (bus_req_valid),
    .bus_req_ready     (bus_req_ready),
    .bus_req_msg       (bus_req_msg),
    .bus_req_address   (bus_req_address),
    .bus_wdata_valid   (bus_wdata_valid),
    .bus_wdata_ready   (bus_wdata_ready),
    .bus_resp_valid    (bus_resp_valid),
    .bus_resp_ready    (bus_resp_ready),
    .bus_resp_msg      (bus_resp_msg),
    .bus_resp_last     (bus_resp_last),
    .cache_req_valid   (cache_req_valid),
    .cache_req_ready   (cache_req_ready),
    .cache_req_write   (cache_req_write),
    .cache_req_address (cache_req_address),
    .cache_resp_valid  (cache_resp_valid),
    .beat_last         (beat_last),
    .beat_clear        (beat_clear),
    .beat_write        (beat_write),
    .beat_advance      (beat_advance),
    .line_load         (line_load)
  );

  // the buffer's line goes straight to the cache, its current slice to the bus
  line_buffer #(
    .CACHE_WORDS_LOG2 (CACHE_WORDS_LOG2),
    .BUS_WORDS_LOG2   (BUS_WORDS_LOG2)
  ) u_line_buffer (
    .clock           (clock),
    .reset           (reset),
    .beat_clear      (beat_clear),
    .beat_write      (beat_write),
    .beat_advance    (beat_advance),
    .line_load       (line_load),
    .bus_wdata       (bus_wdata),
    .cache_resp_data (cache_resp_data),
    .line_data       (cache_req_data),
    .beat_data       (bus_resp_data),
    .beat_last       (beat_last)
  );

endmodule

// ==== source/bridge_control.sv ====
`timescale 1ns/1ps

module bridge_control #(
  parameter int CACHE_WORDS_LOG2 = 2,
  parameter int BUS_WORDS_LOG2   = 1
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       bus_req_valid,
  output logic                       bus_req_ready,
  input  bus_msg_pkg::bus_msg_t      bus_req_msg,
  input  bus_geometry_pkg::address_t bus_req_address,
  input  logic                       bus_wdata_valid,
  output logic                       bus_wdata_ready,
  output logic                       bus_resp_valid,
  input  logic                       bus_resp_ready,
  output bus_msg_pkg::bus_msg_t      bus_resp_msg,
  output logic                       bus_resp_last,
  output logic                       cache_req_valid,
  input  logic                       cache_req_ready,
  output logic                       cache_req_write,
  output bus_geometry_pkg::address_t cache_req_address,
  input  logic                       cache_resp_valid,
  input  logic                       beat_last,
  output logic                       beat_clear,
  output logic                       beat_write,
  output logic                       beat_advance,
  output logic                       line_load
);

  typedef enum logic [2:0] {
    idle,          // waiting for a bus request
    collect,       // gathering write-back beats
    cache_request, // presenting the line request to the cache
    cache_wait,    // request taken, waiting for the cache response
    respond,       // streaming read_data beats
    ack            // presenting write_ack
  } bridge_state_t;

  // word offset bits inside a line
  localparam bus_geometry_pkg::address_t offset_mask =
    bus_geometry_pkg::address_t'((1 << CACHE_WORDS_LOG2) - 1);

  bridge_state_t              state;
  bridge_state_t              state_next;
  bus_msg_pkg::bus_msg_t      req_msg;     // message of the transaction in flight
  bus_geometry_pkg::address_t req_address; // line-aligned address
  logic                       req_accept;
  logic                       is_write;

  // catch a line/bus pairing the buffer cannot split
  if (BUS_WORDS_LOG2 > CACHE_WORDS_LOG2 || CACHE_WORDS_LOG2 - BUS_WORDS_LOG2 > 3) begin : g_ratio
    $error("bus must be no wider than a line and a line at most 8 beats");
  end

  assign req_accept = bus_req_valid && bus_req_ready;
  assign is_write   = req_msg == bus_msg_pkg::write_req;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= idle;
      req_msg <= bus_msg_pkg::no_req;
    end else begin
      state <= state_next;
      if (req_accept) begin
        req_msg <= bus_req_msg;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req_accept) begin
      req_address <= bus_req_address & ~offset_mask; // offset bits dropped here
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (req_accept) begin
          state_next = (bus_req_msg == bus_msg_pkg::write_req) ? collect : cache_request;
        end
      end
      collect: begin
        if (beat_write && beat_last) begin
          state_next = cache_request; // final slice lands this edge
        end
      end
      cache_request: begin
        if (cache_req_ready) begin
          state_next = cache_wait;
        end
      end
      cache_wait: begin
        if (cache_resp_valid) begin
          state_next = is_write ? ack : respond;
        end
      end
      respond: begin
        if (bus_resp_ready && beat_last) begin
          state_next = idle;
        end
      end
      ack: begin
        if (bus_resp_ready) begin
          state_next = idle;
        end
      end
      default: state_next = idle;
    endcase
  end

  assign bus_req_ready     = state == idle;
  assign bus_wdata_ready   = state == collect;
  assign cache_req_valid   = state == cache_request;
  assign cache_req_write   = is_write;
  assign cache_req_address = req_address;
  assign bus_resp_valid    = (state == respond) || (state == ack);
  assign bus_resp_last     = (state == ack) || ((state == respond) && beat_last);
  assign bus_resp_msg      = (state == respond) ? bus_msg_pkg::read_data :
                             (state == ack)     ? bus_msg_pkg::write_ack :
                                                  bus_msg_pkg::no_req;

  // line buffer sequencing
  assign beat_clear   = req_accept; // every transaction starts at slice 0
  assign beat_write   = (state == collect) && bus_wdata_valid;
  assign beat_advance = (state == respond) && bus_resp_ready && !beat_last;
  assign line_load    = (state == cache_wait) && cache_resp_valid && !is_write;

  // a stalled cache request keeps its fields
  cache_req_hold: assert property (@(posedge clock) disable iff (reset)
    cache_req_valid && !cache_req_ready |=>
      cache_req_valid && $stable(cache_req_write) && $stable(cache_req_address));

  // a stalled bus response keeps its fields
  bus_resp_hold: assert property (@(posedge clock) disable iff (reset)
    bus_resp_valid && !bus_resp_ready |=>
      bus_resp_valid && $stable(bus_resp_msg) && $stable(bus_resp_last));

  // the cache only answers a request it has taken
  cache_resp_expected: assert property (@(posedge clock) disable iff (reset)
    cache_resp_valid |-> state == cache_wait);

endmodule

// ==== source/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer #(
  parameter int CACHE_WORDS_LOG2 = 2,
  parameter int BUS_WORDS_LOG2   = 1
) (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic                                                  beat_clear,
  input  logic                                                  beat_write,
  input  logic                                                  beat_advance,
  input  logic                                                  line_load,
  input  bus_geometry_pkg::word_t [(1 << BUS_WORDS_LOG2)-1:0]   bus_wdata,
  input  bus_geometry_pkg::word_t [(1 << CACHE_WORDS_LOG2)-1:0] cache_resp_data,
  output bus_geometry_pkg::word_t [(1 << CACHE_WORDS_LOG2)-1:0] line_data,
  output bus_geometry_pkg::word_t [(1 << BUS_WORDS_LOG2)-1:0]   beat_data,
  output logic                                                  beat_last
);

  localparam int cache_words = 1 << CACHE_WORDS_LOG2;
  localparam int bus_words   = 1 << BUS_WORDS_LOG2;
  localparam int beat_ratio  = 1 << (CACHE_WORDS_LOG2 - BUS_WORDS_LOG2); // beats per line

  localparam bus_geometry_pkg::beat_count_t last_beat =
    bus_geometry_pkg::beat_count_t'(beat_ratio - 1);

  bus_geometry_pkg::word_t [cache_words-1:0] line_q;
  bus_geometry_pkg::beat_count_t             beat_index;
  logic                                      index_valid; // index still names a slice

  always_ff @(posedge clock) begin
    if (reset) begin
      beat_index <= '0;
    end else if (beat_clear) begin
      beat_index <= '0;
    end else if (beat_write || beat_advance) begin
      beat_index <= beat_index + 1'b1; // after the last write it points past the line
    end
  end

  always_ff @(posedge clock) begin
    if (line_load) begin
      line_q <= cache_resp_data;
    end else if (beat_write) begin
      line_q[beat_index*bus_words +: bus_words] <= bus_wdata;
    end
  end

  assign index_valid = beat_index <= last_beat;
  assign line_data   = line_q;
  assign beat_last   = beat_index == last_beat;

  // zero past the end, which is what a write_ack carries
  assign beat_data = index_valid ? line_q[beat_index*bus_words +: bus_words] : '0;

  // the controller never steps beyond the final slice
  beat_in_range: assert property (@(posedge clock) disable iff (reset)
    (beat_write || beat_advance) |-> index_valid);

endmodule

// ==== source/bus_geometry_pkg.sv ====
package bus_geometry_pkg;

  // bits per word, the same on both sides of the bridge
  localparam int data_width = 32;

  localparam int address_width = 32;

  // wide enough to index 8 beats and still hold the past-the-end value
  localparam int beat_count_width = 4;

  // one data word
  typedef logic [data_width-1:0] word_t;

  // word address, the low line-offset bits select a word inside the line
  typedef logic [address_width-1:0] address_t;

  // beat index inside one line
  typedef logic [beat_count_width-1:0] beat_count_t;

endpackage

// ==== source/bus_msg_pkg.sv ====
package bus_msg_pkg;

  // codes carried on the bus request and response channels
  typedef enum logic [2:0] {
    no_req    = 3'd0, // channel idle
    read_req  = 3'd1, // fetch a whole line from the cache
    write_req = 3'd2, // write back a whole line, beats follow on write data
    read_data = 3'd3, // one bus-width slice of a fetched line
    write_ack = 3'd4  // write-back done, carries no data
  } bus_msg_t;

endpackage
